// ==== design/loopDataPkg.sv ====
/*
  Loop filter data path types.
  Phase-error sample, gain selector and the 32-bit frequency word,
  plus the power-of-two gain scaling shared by the lead and lag paths.
*/

package loopDataPkg;

    typedef logic signed [11:0] errorSample;   // raw phase error from the detector
    typedef logic        [4:0]  gainCode;      // 0 is off, 11 is unity
    typedef logic signed [31:0] freqWord;      // scaled errors, accumulator, output

    // gain code g scales by 2**(g-11)
    // code 31 lands the sample in the top 12 bits of the word
    function automatic freqWord scaleError(
        input errorSample err,
        input gainCode    gain
    );
        freqWord wide;
        freqWord scaled;
        wide = {{20{err[11]}}, err};   // sign extend first
        if (gain == 5'd0) begin
            scaled = '0;
        end else if (gain < 5'd11) begin
            scaled = wide >>> (5'd11 - gain);   // floors toward minus infinity
        end else begin
            scaled = wide <<< (gain - 5'd11);
        end
        return scaled;
    endfunction

endpackage

// ==== design/loopCtrlPkg.sv ====
/*
  Loop filter control types.
  Configuration that steers the filter and the status it reports back.
*/

package loopCtrlPkg;

    typedef struct packed {
        loopDataPkg::gainCode lead;         // proportional gain
        loopDataPkg::gainCode lag;          // integral gain
        logic                 invertError;  // flip error polarity
        logic                 zeroError;    // open the loop
        loopDataPkg::freqWord limit;        // accumulator clamp, non-negative
    } loopConfig;

    typedef struct packed {
        logic        satPos;      // accumulator pinned at +limit
        logic        satNeg;      // accumulator pinned at -limit
        logic [15:0] lockCount;   // consecutive small errors
    } loopStatus;

endpackage

// ==== design/errorFrontEnd.sv ====
/*
  Error front end of the loop filter.
  Accepts one phase-error sample per four-phase req/ack cycle, holding off
  while the output port is still busy. Conditions the sample (invert or
  zero), strobes it into both filter paths and keeps a count of
  consecutive samples whose magnitude is below the sync threshold.
*/

`timescale 1ns/1ps

module errorFrontEnd #(
    parameter int lockCountWidth = 16
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          inReq,
    input  loopDataPkg::errorSample       inError,
    output logic                          inAck,
    input  logic [11:0]                   syncThreshold,
    input  loopCtrlPkg::loopConfig        cfg,
    input  logic                          outBusy,
    output logic                          sampleStrobe,
    output loopDataPkg::errorSample       condError,
    output logic [lockCountWidth-1:0]     lockCount
);

    typedef enum logic {
        stIdle,
        stAcked
    } frontState;

    frontState               state;
    loopDataPkg::errorSample shapedError;
    logic [11:0]             absError;
    logic                    smallError;
    logic                    accept;

    // take a sample only when the last result has left the output port
    assign accept = (state == stIdle) && inReq && !outBusy;
    assign inAck  = (state == stAcked);

    always_comb begin
        if (cfg.zeroError) begin
            shapedError = '0;
        end else if (cfg.invertError) begin
            shapedError = -inError;
        end else begin
            shapedError = inError;
        end
    end

    // lock detect looks at the raw error, before conditioning
    assign absError   = inError[11] ? -inError : inError;   // -2048 maps to 2048 unsigned
    assign smallError = absError < syncThreshold;

    // four-phase handshake on the input side
    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= stIdle;
            sampleStrobe <= 1'b0;
        end else begin
            sampleStrobe <= accept;   // one pulse per captured sample
            case (state)
                stIdle: if (accept) state <= stAcked;
                stAcked: if (!inReq) state <= stIdle;   // req dropped, release ack
                default: state <= stIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            condError <= shapedError;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            lockCount <= '0;
        end else if (accept) begin
            if (!smallError) begin
                lockCount <= '0;   // one big error breaks the run
            end else if (lockCount != '1) begin
                lockCount <= lockCount + 1'b1;
            end
        end
    end

endmodule

// ==== design/proportionalPath.sv ====
/*
  Proportional (lead) path of the loop filter.
  Scales each strobed error by the lead gain and registers the term,
  flagging it valid for one cycle.
*/

`timescale 1ns/1ps

module proportionalPath (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    sampleStrobe,
    input  loopDataPkg::errorSample condError,
    input  loopDataPkg::gainCode    lead,
    output loopDataPkg::freqWord    leadTerm,
    output logic                    leadValid
);

    loopDataPkg::freqWord scaledTerm;

    assign scaledTerm = loopDataPkg::scaleError(condError, lead);

    // valid lines up with the integral path, both one cycle after the strobe
    always_ff @(posedge clk) begin
        if (reset) begin
            leadValid <= 1'b0;
        end else begin
            leadValid <= sampleStrobe;
        end
    end

    // term holds between updates
    always_ff @(posedge clk) begin
        if (sampleStrobe) begin
            leadTerm <= scaledTerm;
        end
    end

endmodule

// ==== design/integralPath.sv ====
/*
  Integral (lag) path of the loop filter.
  Adds the lag-scaled error to a running accumulator and clamps it to
  the symmetric range -limit to +limit. The saturation flags report which
  side, if any, the last update was clamped to. clearAccum empties the
  accumulator and flags and wins over a coinciding update.
*/

`timescale 1ns/1ps

module integralPath (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    sampleStrobe,
    input  loopDataPkg::errorSample condError,
    input  loopDataPkg::gainCode    lag,
    input  loopDataPkg::freqWord    limit,
    input  logic                    clearAccum,
    output loopDataPkg::freqWord    lagAccum,
    output logic                    satPos,
    output logic                    satNeg,
    output logic                    lagValid
);

    loopDataPkg::freqWord lagTerm;
    logic signed [32:0]   wideSum;
    logic signed [32:0]   upperLimit;
    logic signed [32:0]   lowerLimit;

    assign lagTerm = loopDataPkg::scaleError(condError, lag);

    // one guard bit, so the sum and the bounds compare without overflow
    assign wideSum    = {lagAccum[31], lagAccum} + {lagTerm[31], lagTerm};
    assign upperLimit = {limit[31], limit};
    assign lowerLimit = -upperLimit;

    always_ff @(posedge clk) begin
        if (reset || clearAccum) begin
            lagAccum <= '0;
            satPos   <= 1'b0;
            satNeg   <= 1'b0;
        end else if (sampleStrobe) begin
            if (wideSum > upperLimit) begin
                lagAccum <= limit;                 // pinned high
                satPos   <= 1'b1;
                satNeg   <= 1'b0;
            end else if (wideSum < lowerLimit) begin
                lagAccum <= lowerLimit[31:0];      // pinned low
                satPos   <= 1'b0;
                satNeg   <= 1'b1;
            end else begin
                lagAccum <= wideSum[31:0];         // in range, guard bit is redundant
                satPos   <= 1'b0;
                satNeg   <= 1'b0;
            end
        end
    end

    // still pulses on a cleared update so the combiner emits a result
    always_ff @(posedge clk) begin
        if (reset) begin
            lagValid <= 1'b0;
        end else begin
            lagValid <= sampleStrobe;
        end
    end

endmodule

// ==== design/loopCombiner.sv ====
/*
  Output stage of the loop filter.
  Sums the lead term and the lag accumulator into the frequency word and
  hands it to the oscillator over a four-phase req/ack port. Busy stays
  high until that port is back to idle, which throttles the input side.
*/

`timescale 1ns/1ps

module loopCombiner (
    input  logic                 clk,
    input  logic                 reset,
    input  loopDataPkg::freqWord leadTerm,
    input  logic                 leadValid,
    input  loopDataPkg::freqWord lagAccum,
    input  logic                 lagValid,
    output logic                 outReq,
    input  logic                 outAck,
    output loopDataPkg::freqWord outFreq,
    output logic                 outBusy
);

    typedef enum logic [1:0] {
        stIdle,
        stRequest,   // word presented, waiting for ack
        stRelease    // req dropped, waiting for ack to fall
    } combState;

    combState state;

    assign outReq  = (state == stRequest);
    assign outBusy = (state != stIdle);

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= stIdle;
            outFreq <= '0;
        end else begin
            case (state)
                stIdle: begin
                    if (leadValid && lagValid) begin
                        outFreq <= leadTerm + lagAccum;   // wraps at 32 bits
                        state   <= stRequest;
                    end
                end
                stRequest: if (outAck) state <= stRelease;
                stRelease: if (!outAck) state <= stIdle;
                default: state <= stIdle;
            endcase
        end
    end

endmodule

// ==== design/loopFilterTop.sv ====
/*
  Loop filter top level.
  Lead/lag filter for a tracking loop: a conditioned phase error feeds a
  proportional path and a clamped integral path, whose sum goes to the
  oscillator as a 32-bit frequency word. Both ports are four-phase req/ack.
*/

`timescale 1ns/1ps

module loopFilterTop #(
    parameter int lockCountWidth = 16
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    inReq,
    input  loopDataPkg::errorSample inError,
    output logic                    inAck,
    input  loopCtrlPkg::loopConfig  cfg,
    input  logic [11:0]             syncThreshold,
    input  logic                    clearAccum,
    output logic                    outReq,
    input  logic                    outAck,
    output loopDataPkg::freqWord    outFreq,
    output loopCtrlPkg::loopStatus  status
);

    logic                        sampleStrobe;
    loopDataPkg::errorSample     condError;
    logic [lockCountWidth-1:0]   lockCount;
    loopDataPkg::freqWord        leadTerm;
    logic                        leadValid;
    loopDataPkg::freqWord        lagAccum;
    logic                        lagValid;
    logic                        satPos;
    logic                        satNeg;
    logic                        outBusy;

    errorFrontEnd #(
        .lockCountWidth(lockCountWidth)
    ) i_frontEnd (
        .clk, .reset, .inReq, .inError, .inAck, .syncThreshold, .cfg,
        .outBusy, .sampleStrobe, .condError, .lockCount
    );

    proportionalPath i_lead (
        .clk, .reset, .sampleStrobe, .condError,
        .lead(cfg.lead), .leadTerm, .leadValid
    );

    integralPath i_lag (
        .clk, .reset, .sampleStrobe, .condError,
        .lag(cfg.lag), .limit(cfg.limit), .clearAccum,
        .lagAccum, .satPos, .satNeg, .lagValid
    );

    loopCombiner i_combiner (
        .clk, .reset, .leadTerm, .leadValid, .lagAccum, .lagValid,
        .outReq, .outAck, .outFreq, .outBusy
    );

    assign status.satPos    = satPos;
    assign status.satNeg    = satNeg;
    assign status.lockCount = 16'(lockCount);   // status field is fixed at 16 bits

endmodule

// ==== verification/loopFilter_assertions.sv ====
/*
  Protocol assertions for the loop filter.
  Bound to the top level, watching both four-phase ports and the
  saturation flags.
*/

`timescale 1ns/1ps

module loopFilterAssertions (
    input logic                   clk,
    input logic                   reset,
    input logic                   inReq,
    input logic                   inAck,
    input logic                   outReq,
    input logic                   outAck,
    input loopDataPkg::freqWord   outFreq,
    input loopCtrlPkg::loopStatus status
);

    ackNeedsReq: assert property (@(posedge clk) disable iff (reset)
        $rose(inAck) |-> inReq)
        else $error("inAck rose without inReq");

    ackDropsAfterReq: assert property (@(posedge clk) disable iff (reset)
        $fell(inAck) |-> !inReq)
        else $error("inAck fell while inReq was still high");

    // word must not move while the oscillator has not taken it
    freqHeld: assert property (@(posedge clk) disable iff (reset)
        (outReq && !outAck) |=> $stable(outFreq))
        else $error("outFreq changed while outReq waited for outAck");

    reqDropsAfterAck: assert property (@(posedge clk) disable iff (reset)
        $fell(outReq) |-> outAck)
        else $error("outReq fell without outAck");

    satExclusive: assert property (@(posedge clk) disable iff (reset)
        !(status.satPos && status.satNeg))
        else $error("satPos and satNeg high together");

endmodule

bind loopFilterTop loopFilterAssertions i_assertions (
    .clk(clk),
    .reset(reset),
    .inReq(inReq),
    .inAck(inAck),
    .outReq(outReq),
    .outAck(outAck),
    .outFreq(outFreq),
    .status(status)
);

// ==== verification/loopFilterTb.sv ====
/*
  Testbench for the loop filter.
  Reads one sample per line from the stimulus file, pushes it through the
  four-phase input port and answers the output port after a random delay.
  Checks outFreq and the status word against the expected columns and
  checks that a new sample is only taken after the previous result left.
*/

`timescale 1ns/1ps

module loopFilterTb;

    localparam int lockCountWidth = 16;
    localparam int waitLimit      = 200;   // cycles per handshake wait

    typedef struct packed {
        loopCtrlPkg::loopConfig  cfg;
        logic [11:0]             syncThreshold;
        logic                    clearAccum;
        loopDataPkg::errorSample sample;
        loopDataPkg::freqWord    expFreq;
        loopCtrlPkg::loopStatus  expStatus;
    } vectorLine;

    logic                    clk = 1'b0;
    logic                    reset;
    logic                    inReq;
    loopDataPkg::errorSample inError;
    logic                    inAck;
    loopCtrlPkg::loopConfig  cfg;
    logic [11:0]             syncThreshold;
    logic                    clearAccum;
    logic                    outReq;
    logic                    outAck;
    loopDataPkg::freqWord    outFreq;
    loopCtrlPkg::loopStatus  status;

    vectorLine vectors[$];
    int        errorCount    = 0;
    int        timeoutCount  = 0;
    int        releasedCount = 0;   // output handshakes fully completed

    always #5 clk = ~clk;

    loopFilterTop #(
        .lockCountWidth(lockCountWidth)
    ) i_dut (
        .clk, .reset, .inReq, .inError, .inAck, .cfg, .syncThreshold,
        .clearAccum, .outReq, .outAck, .outFreq, .status
    );

    task automatic finishRun();
        $display("errors: %0d  timeouts: %0d  samples: %0d  outputs: %0d",
                 errorCount, timeoutCount, vectors.size(), releasedCount);
        if (errorCount == 0 && timeoutCount == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    endtask

    task automatic reportTimeout(input string what);
        $display("TIMEOUT at %0t: %s", $time, what);
        timeoutCount++;
    endtask

    task automatic loadVectors();
        int        fd;
        int        got;
        string     line;
        vectorLine v;
        int        lead, lag, invert, zero, limit, thresh;
        int        clear, err, freq, satP, satN, lock;
        fd = $fopen("verification/loopFilter_input.txt", "r");
        assert (fd != 0) else begin
            $display("could not open the stimulus file");
            errorCount++;
        end
        if (fd != 0) begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() == 0 || line.getc(0) == "#") continue;   // column notes
                got = $sscanf(line, "%d %d %d %d %d %d %d %d %d %d %d %d", lead, lag,
                              invert, zero, limit, thresh, clear, err, freq, satP, satN, lock);
                if (got == 12) begin
                    v.cfg.lead             = 5'(lead);
                    v.cfg.lag              = 5'(lag);
                    v.cfg.invertError      = invert[0];
                    v.cfg.zeroError        = zero[0];
                    v.cfg.limit            = limit;
                    v.syncThreshold        = 12'(thresh);
                    v.clearAccum           = clear[0];
                    v.sample               = 12'(err);
                    v.expFreq              = freq;
                    v.expStatus.satPos     = satP[0];
                    v.expStatus.satNeg     = satN[0];
                    v.expStatus.lockCount  = 16'(lock);
                    vectors.push_back(v);
                end else if (got > 0) begin
                    $display("malformed stimulus line: %s", line);
                    errorCount++;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic checkOutput(input int k, input vectorLine v);
        assert (outFreq == v.expFreq) else begin
            $display("FAIL %0t outFreq sample %0d expected %0d actual %0d",
                     $time, k, $signed(v.expFreq), outFreq);
            errorCount++;
        end
        assert (status.satPos == v.expStatus.satPos) else begin
            $display("FAIL %0t satPos sample %0d expected %0b actual %0b",
                     $time, k, v.expStatus.satPos, status.satPos);
            errorCount++;
        end
        assert (status.satNeg == v.expStatus.satNeg) else begin
            $display("FAIL %0t satNeg sample %0d expected %0b actual %0b",
                     $time, k, v.expStatus.satNeg, status.satNeg);
            errorCount++;
        end
        assert (status.lockCount == v.expStatus.lockCount) else begin
            $display("FAIL %0t lockCount sample %0d expected %0d actual %0d",
                     $time, k, v.expStatus.lockCount, status.lockCount);
            errorCount++;
        end
    endtask

    // input side, next request goes up as soon as the last ack drops
    task automatic driveSamples();
        int waited;
        foreach (vectors[k]) begin
            @(posedge clk);
            cfg           <= vectors[k].cfg;
            syncThreshold <= vectors[k].syncThreshold;
            clearAccum    <= vectors[k].clearAccum;
            inError       <= vectors[k].sample;
            inReq         <= 1'b1;
            waited = 0;
            @(negedge clk);
            while (!inAck && waited < waitLimit) begin
                @(negedge clk);
                waited++;
            end
            if (!inAck) begin
                reportTimeout("inAck never rose for a waiting sample");
                return;
            end
            assert (releasedCount == k) else begin
                $display("back-pressure broken: sample %0d taken at %0t after %0d outputs",
                         k, $time, releasedCount);
                errorCount++;
            end
            @(posedge clk);
            inReq <= 1'b0;
            waited = 0;
            @(negedge clk);
            while (inAck && waited < waitLimit) begin
                @(negedge clk);
                waited++;
            end
            if (inAck) begin
                reportTimeout("inAck stayed high after inReq dropped");
                return;
            end
        end
    endtask

    // output side, plays the oscillator with a random ack delay
    task automatic answerOutputs();
        int waited;
        int delay;
        for (int k = 0; k < vectors.size(); k++) begin
            waited = 0;
            @(negedge clk);
            while (!outReq && waited < waitLimit) begin
                @(negedge clk);
                waited++;
            end
            if (!outReq) begin
                reportTimeout("outReq never rose, a result was lost");
                return;
            end
            checkOutput(k, vectors[k]);
            delay = $urandom % 4;
            repeat (delay) @(posedge clk);
            @(posedge clk);
            outAck <= 1'b1;
            waited = 0;
            @(negedge clk);
            while (outReq && waited < waitLimit) begin
                @(negedge clk);
                waited++;
            end
            if (outReq) begin
                reportTimeout("outReq stayed high after outAck");
                return;
            end
            @(posedge clk);
            outAck <= 1'b0;
            releasedCount++;
        end
        repeat (20) begin
            @(negedge clk);
            assert (!outReq) else begin
                $display("extra result presented at %0t with no sample behind it", $time);
                errorCount++;
            end
        end
    endtask

    initial begin
        void'($urandom(6));
        reset         = 1'b1;
        inReq         = 1'b0;
        inError       = '0;
        cfg           = '0;
        syncThreshold = '0;
        clearAccum    = 1'b0;
        outAck        = 1'b0;
        loadVectors();
        assert (vectors.size() > 0) else begin
            $display("no stimulus lines were read");
            errorCount++;
        end
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        fork
            driveSamples();
            answerOutputs();
        join
        finishRun();
    end

endmodule

// ==== verification/loopFilter_input.txt ====
# lead lag invert zero limit syncThreshold clearAccum error | expected outFreq satPos satNeg lockCount
# all values decimal, one sample per line
11 0 0 0 1000 64 0 100 100 0 0 0
12 0 0 0 1000 64 0 -37 -74 0 0 1
10 0 0 0 1000 64 0 -37 -19 0 0 2
10 0 0 0 1000 64 0 37 18 0 0 3
1 0 0 0 1000 64 0 2047 1 0 0 0
1 0 0 0 1000 64 0 -1 -1 0 0 1
31 0 0 0 1000 64 0 100 104857600 0 0 0
31 0 0 0 1000 64 0 -2048 -2147483648 0 0 0
20 0 0 0 1000 64 0 5 2560 0 0 1
0 11 0 0 100000 64 0 300 300 0 0 0
0 11 0 0 100000 64 0 -50 250 0 0 1
0 13 0 0 100000 64 0 40 410 0 0 2
0 9 0 0 100000 64 0 -7 408 0 0 3
0 14 0 0 1000 64 0 100 1000 1 0 0
0 14 0 0 1000 64 0 10 1000 1 0 1
0 14 0 0 1000 64 0 -50 600 0 0 2
0 16 0 0 1000 64 0 -100 -1000 0 1 0
0 16 0 0 1000 64 0 -1 -1000 0 1 1
11 16 0 0 1000 64 0 20 -340 0 0 2
11 11 1 0 1000 64 0 30 -420 0 0 3
11 11 0 1 1000 64 0 500 -390 0 0 0
11 11 0 0 1000 64 1 25 25 0 0 1
0 11 0 0 1000 64 0 40 40 0 0 2
0 12 1 0 1000 64 0 40 -40 0 0 3
11 0 0 0 1000 16 0 15 -25 0 0 4
11 0 0 0 1000 16 0 -15 -55 0 0 5
11 0 0 0 1000 16 0 16 -24 0 0 0
11 0 0 0 1000 16 0 3 -37 0 0 1
0 0 0 0 1000 4095 0 -2048 -40 0 0 2

// ==== verilog.f ====
design/loopDataPkg.sv
design/loopCtrlPkg.sv
design/errorFrontEnd.sv
design/proportionalPath.sv
design/integralPath.sv
design/loopCombiner.sv
design/loopFilterTop.sv
verification/loopFilter_assertions.sv
verification/loopFilterTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# builds the loop filter testbench with Verilator, runs it and scans the log

cd "$(dirname "$0")" || exit 1

logFile=sim.log
buildDir=obj_dir

verilator --binary --timing --assert -Wno-fatal -f verilog.f \
    --top-module loopFilterTb --Mdir "$buildDir" -o loopFilterSim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$buildDir/loopFilterSim" > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

if grep -q "tests failed" "$logFile"; then
    echo "simulation reported failures, see $logFile"
    exit 1
fi

echo "simulation clean"
exit 0
